//--- all.f
+incdir+verilog
verilog/wiscPkg.sv
verilog/control.sv
verilog/instrFetch.sv
verilog/instrQueue.sv
verilog/decodeStage.sv
verilog/decodeTop.sv
sim/decodeTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --timing --assert
TOP = decodeTb
FILELIST = all.f
BUILD = obj_dir
LOG = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) | tee $(LOG)
	grep -q "^SIMULATION PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- sim/decodeTb.sv
`include "wiscDecode_macros.svh"

module decodeTb;

	localparam int depth = `WISC_QUEUE_DEPTH;
	localparam int resetLen = 8 + 4;
	localparam int sweepLen = 31 + 40 + 4;
	localparam int fieldLen = 36 + 40 + 4;
	localparam int orderLen = resetLen + 10 + 30 + 4;
	localparam int pressureLen = resetLen + 2 * depth + 40 + 20;
	localparam int haltLen = 2 * resetLen + 4 + 20 + 12 + 14;
	localparam int runLimit = 3 * (resetLen + sweepLen + fieldLen + orderLen + pressureLen + haltLen);

	logic clk;
	logic reset;
	logic instrValid;
	logic [15:0] instr;
	logic stall;
	logic decodedValid;
	wiscPkg::decodedPacket decoded;
	logic halted;
	logic full;
	logic overflow;

	logic [15:0] lfsr = 16'd46226;
	logic [15:0] modelPc;
	wiscPkg::decodedPacket expected [$];
	logic stallModel;
	logic haltSeen;
	int heldCount;
	int cycle = 0;
	int lastStrobeEdge = 0;
	int gotCount = 0;
	int markCount = 0;
	int firstArrival = 0;
	int tests = 0;
	int checks = 0;
	int errors = 0;

	decodeTop decodeTop_inst
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.stall(stall),
		.decodedValid(decodedValid),
		.decoded(decoded),
		.halted(halted),
		.full(full),
		.overflow(overflow)
	);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
		cycle <= cycle + 1; // number of the edge just taken.

	initial
	begin
		repeat (runLimit) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run timed out", runLimit);
		$display("SIMULATION FAILED");
		$finish;
	end

	// taps 16 14 13 11.
	function automatic logic [15:0] randBits(input int n);
		logic [15:0] bits;
		logic fb;
		int i;
		bits = '0;
		for (i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			bits = {bits[14:0], fb};
		end
		return bits;
	endfunction

	function automatic logic [15:0] randWord();
		logic [15:0] w;
		w = randBits(16);
		if (w[15:11] == 5'd0)
			w[15:11] = 5'd1; // keep halt out of plain traffic.
		return w;
	endfunction

	function automatic wiscPkg::ctrlSignals refCtrl(input logic [4:0] op);
		logic [10:0] f; // regDst first, i1Fmt last, as in the struct.
		case (op)
			0: f = 11'b00000_000_100;
			1, 2, 3: f = 11'b00000_000_000;
			4: f = 11'b00000_100_000;
			5: f = 11'b01000_100_000;
			6: f = 11'b00000_101_000;
			7: f = 11'b01000_101_000;
			8, 9, 20, 21, 23: f = 11'b01000_001_001;
			10, 11: f = 11'b01000_001_011;
			12, 13, 14, 15: f = 11'b01100_000_000;
			16: f = 11'b01011_010_001;
			17: f = 11'b01010_011_001;
			18: f = 11'b01000_001_010;
			19: f = 11'b01011_001_001;
			22: f = 11'b00000_001_001;
			24: f = 11'b01000_001_000;
			default: f = 11'b10000_001_000;
		endcase
		return wiscPkg::ctrlSignals'({op, f});
	endfunction

	function automatic wiscPkg::decodedPacket refDecode(input logic [15:0] pc, input logic [15:0] w);
		wiscPkg::decodedPacket p;
		wiscPkg::ctrlSignals c;
		c = refCtrl(w[15:11]);
		p.pc = pc;
		p.ctrl = c;
		p.rs = w[10:8];
		p.rt = w[7:5];
		if (c.regDst)
			p.writeReg = w[4:2];
		else if (c.jump && c.regWrite)
			p.writeReg = 3'd7;
		else if (c.i1Fmt)
			p.writeReg = w[7:5];
		else
			p.writeReg = w[10:8];
		if (c.i1Fmt)
			p.immediate = c.zeroExt ? {11'd0, w[4:0]} : {{11{w[4]}}, w[4:0]};
		else if (c.jump && !c.aluSrc)
			p.immediate = {{5{w[10]}}, w[10:0]};
		else
			p.immediate = c.zeroExt ? {8'd0, w[7:0]} : {{8{w[7]}}, w[7:0]};
		return p;
	endfunction

	task automatic checkCtrl(input string name, input wiscPkg::ctrlSignals got,
		input wiscPkg::ctrlSignals exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkDecoded(input string name, input wiscPkg::decodedPacket got,
		input wiscPkg::decodedPacket exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic checkFlag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("CHECK FAILED %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic reportProblem(input string text);
		errors++;
		$display("%s", text);
	endtask

	// outputs are settled by the falling edge.
	always @(negedge clk)
	begin
		if (!reset && decodedValid)
		begin
			if (expected.size() == 0)
				reportProblem($sformatf("unexpected decodedValid with pc %h", decoded.pc));
			else
			begin
				checkCtrl("decoded.ctrl", decoded.ctrl, expected[0].ctrl);
				checkDecoded("decoded", decoded, expected.pop_front());
			end
			if (gotCount == markCount)
				firstArrival = cycle;
			gotCount++;
		end
	end

	task automatic sendWord(input logic [15:0] word);
		@(posedge clk);
		instrValid <= 1'b1;
		instr <= word;
		lastStrobeEdge = cycle + 2;
		if (!haltSeen && !(stallModel && heldCount >= depth))
			expected.push_back(refDecode(modelPc, word));
		if (stallModel)
			heldCount++;
		if (word[15:11] == 5'd0)
			haltSeen = 1'b1;
		modelPc = modelPc + `WISC_PC_STEP; // dropped words still use a pc.
	endtask

	task automatic idle();
		@(posedge clk);
		instrValid <= 1'b0;
	endtask

	task automatic setStall(input logic level);
		@(posedge clk);
		stall <= level;
		stallModel = level;
		heldCount = 0;
	endtask

	task automatic waitDrain(input int limit);
		int n;
		n = 0;
		while (expected.size() != 0 && n < limit)
		begin
			@(posedge clk);
			n++;
		end
		if (expected.size() != 0)
		begin
			reportProblem($sformatf("%0d decoded packets still missing after %0d cycles",
				expected.size(), limit));
			expected.delete();
		end
		repeat (2) @(posedge clk);
	endtask

	task automatic applyReset();
		@(posedge clk);
		reset <= 1'b1;
		instrValid <= 1'b0;
		stall <= 1'b0;
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		modelPc = `WISC_RESET_PC;
		expected.delete();
		stallModel = 1'b0;
		haltSeen = 1'b0;
		heldCount = 0;
		@(negedge clk);
		checkFlag("halted", halted, 1'b0);
		checkFlag("full", full, 1'b0);
		checkFlag("overflow", overflow, 1'b0);
		checkFlag("decodedValid", decodedValid, 1'b0);
	endtask

	task automatic endTest(input string name, input int startErrors);
		tests++;
		$display("test %s finished with %0d errors", name, errors - startErrors);
	endtask

	task automatic opcodeSweep();
		int startErrors;
		int op;
		logic [15:0] operands;
		startErrors = errors;
		for (op = 1; op < 32; op++)
		begin
			operands = randBits(11);
			sendWord({op[4:0], operands[10:0]});
		end
		idle();
		waitDrain(40);
		endTest("opcode sweep", startErrors);
	endtask

	task automatic fieldsAndImmediates();
		logic [4:0] formats [9] = '{5'd25, 5'd8, 5'd10, 5'd24, 5'd18, 5'd4, 5'd6, 5'd5, 5'd7};
		int startErrors;
		int i;
		logic [15:0] operands;
		startErrors = errors;
		for (i = 0; i < 9; i++)
		begin
			operands = randBits(11);
			sendWord({formats[i], operands[10:0]});
			operands = randBits(11);
			sendWord({formats[i], operands[10:0]});
			sendWord({formats[i], 11'h7ff}); // every sign bit set.
			sendWord({formats[i], 11'h000});
		end
		idle();
		waitDrain(40);
		endTest("fields and immediates", startErrors);
	endtask

	task automatic orderAndPc();
		int startErrors;
		int firstEdge;
		int i;
		startErrors = errors;
		applyReset();
		markCount = gotCount;
		firstEdge = 0;
		for (i = 0; i < 10; i++)
		begin
			sendWord(randWord());
			if (i == 0)
				firstEdge = lastStrobeEdge;
		end
		idle();
		waitDrain(30);
		checks++;
		if (firstArrival - firstEdge + 1 != 3)
			reportProblem($sformatf("first packet came %0d edges after its strobe, not 3",
				firstArrival - firstEdge + 1));
		endTest("order and pc", startErrors);
	endtask

	task automatic backPressure();
		int startErrors;
		int i;
		startErrors = errors;
		applyReset();
		setStall(1'b1);
		markCount = gotCount;
		for (i = 0; i < depth; i++)
			sendWord(randWord());
		idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkFlag("full", full, 1'b1);
		checkFlag("overflow", overflow, 1'b0);
		sendWord(randWord());
		idle();
		repeat (3) @(posedge clk);
		@(negedge clk);
		checkFlag("overflow", overflow, 1'b1);
		setStall(1'b0);
		waitDrain(depth + 20);
		checks++;
		if (gotCount - markCount != depth)
			reportProblem($sformatf("%0d packets left the queue after stall, expected %0d",
				gotCount - markCount, depth));
		sendWord(randWord()); // its pc shows the gap of the dropped word.
		idle();
		waitDrain(10);
		endTest("back-pressure", startErrors);
	endtask

	task automatic haltHold();
		int startErrors;
		int i;
		logic [15:0] operands;
		startErrors = errors;
		applyReset();
		markCount = gotCount;
		operands = randBits(11);
		sendWord({5'd0, operands[10:0]});
		for (i = 0; i < 3; i++)
			sendWord(randWord());
		idle();
		waitDrain(20);
		repeat (10) @(posedge clk);
		@(negedge clk);
		checkFlag("halted", halted, 1'b1);
		checks++;
		if (gotCount - markCount != 1)
			reportProblem($sformatf("%0d packets came out around the halt, expected 1",
				gotCount - markCount));
		applyReset();
		sendWord(randWord()); // pc is back at the reset value.
		idle();
		waitDrain(10);
		endTest("halt", startErrors);
	endtask

	initial
	begin
		reset = 1'b1;
		instrValid = 1'b0;
		instr = '0;
		stall = 1'b0;
		applyReset();
		opcodeSweep();
		fieldsAndImmediates();
		orderAndPc();
		backPressure();
		haltHold();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- verilog/decodeTop.sv
`include "wiscDecode_macros.svh"

module decodeTop
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  logic [`WISC_WORD_WIDTH-1:0] instr,
	input  logic stall,
	output logic decodedValid,
	output wiscPkg::decodedPacket decoded,
	output logic halted,
	output logic full,
	output logic overflow
);

	logic push;
	logic pop;
	logic empty;
	wiscPkg::fetchPacket pushData;
	wiscPkg::fetchPacket popData;

	instrFetch instrFetch_inst
	(
		.clk(clk),
		.reset(reset),
		.instrValid(instrValid),
		.instr(instr),
		.push(push),
		.pushData(pushData)
	);

	instrQueue #(.depth(`WISC_QUEUE_DEPTH)) instrQueue_inst
	(
		.clk(clk),
		.reset(reset),
		.push(push),
		.pushData(pushData),
		.pop(pop),
		.popData(popData),
		.empty(empty),
		.full(full),
		.overflow(overflow)
	);

	decodeStage decodeStage_inst
	(
		.clk(clk),
		.reset(reset),
		.stall(stall),
		.empty(empty),
		.popData(popData),
		.pop(pop),
		.decodedValid(decodedValid),
		.decoded(decoded),
		.halted(halted)
	);

endmodule

//--- verilog/decodeStage.sv
module decodeStage
(
	input  logic clk,
	input  logic reset,
	input  logic stall,
	input  logic empty,
	input  wiscPkg::fetchPacket popData,
	output logic pop,
	output logic decodedValid,
	output wiscPkg::decodedPacket decoded,
	output logic halted
);

	wiscPkg::ctrlSignals ctrl;
	logic err;
	logic [15:0] word;
	logic [2:0] writeReg;
	logic [15:0] immediate;

	assign word = popData.instr;
	assign pop = !empty && !stall && !halted;

	control control_inst
	(
		.opcode(word[15:11]),
		.regDst(ctrl.regDst),
		.aluSrc(ctrl.aluSrc),
		.aluOp(ctrl.aluOp),
		.branch(ctrl.branch),
		.memRead(ctrl.memRead),
		.memWrite(ctrl.memWrite),
		.jump(ctrl.jump),
		.memToReg(ctrl.memToReg),
		.regWrite(ctrl.regWrite),
		.err(err),
		.halt(ctrl.halt),
		.zeroExt(ctrl.zeroExt),
		.i1Fmt(ctrl.i1Fmt)
	);

	always_comb
	begin
		if (ctrl.regDst)
			writeReg = word[4:2];
		else if (ctrl.jump && ctrl.regWrite)
			writeReg = 3'd7; // link register.
		else if (ctrl.i1Fmt)
			writeReg = word[7:5];
		else
			writeReg = word[10:8];
		if (ctrl.i1Fmt)
			immediate = {{11{word[4] && !ctrl.zeroExt}}, word[4:0]};
		else if (ctrl.jump && !ctrl.aluSrc)
			immediate = {{5{word[10]}}, word[10:0]}; // pc relative displacement.
		else
			immediate = {{8{word[7] && !ctrl.zeroExt}}, word[7:0]};
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			decodedValid <= 1'b0;
			halted       <= 1'b0;
		end
		else
		begin
			decodedValid <= pop;
			if (pop && ctrl.halt)
				halted <= 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (pop)
			decoded <= '{pc: popData.pc, ctrl: ctrl, rs: word[10:8], rt: word[7:5],
				writeReg: writeReg, immediate: immediate};
	end

	errNeverOnKnownOpcode: assert property (@(posedge clk) disable iff (reset)
		pop && !$isunknown(word[15:11]) |-> !err);

endmodule

//--- verilog/instrQueue.sv
`include "wiscDecode_macros.svh"

module instrQueue
#(
	parameter int depth = `WISC_QUEUE_DEPTH
)
(
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  wiscPkg::fetchPacket pushData,
	input  logic pop,
	output wiscPkg::fetchPacket popData,
	output logic empty,
	output logic full,
	output logic overflow
);

	localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
	localparam int countW = $clog2(depth + 1);

	wiscPkg::fetchPacket mem [depth];
	logic [ptrW-1:0] wrPtr, rdPtr;
	logic [countW-1:0] count;
	logic write;

	assign write = push && !full;
	assign full = (count == countW'(depth));
	assign empty = (count == '0);
	assign popData = mem[rdPtr]; // head shown before the pop edge.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr    <= '0;
			rdPtr    <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end
		else
		begin
			if (write)
				wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + ptrW'(1);
			if (pop)
				rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + ptrW'(1);
			if (write && !pop)
				count <= count + countW'(1);
			else if (pop && !write)
				count <= count - countW'(1);
			if (push && full)
				overflow <= 1'b1; // sticky until reset.
		end
	end

	always_ff @(posedge clk)
	begin
		if (write)
			mem[wrPtr] <= pushData;
	end

	// decode owns the empty check on pop.
	noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) pop |-> !empty);
	countBounded: assert property (@(posedge clk) disable iff (reset) count <= countW'(depth));

endmodule

//--- verilog/instrFetch.sv
`include "wiscDecode_macros.svh"

module instrFetch
(
	input  logic clk,
	input  logic reset,
	input  logic instrValid,
	input  logic [`WISC_WORD_WIDTH-1:0] instr,
	output logic push,
	output wiscPkg::fetchPacket pushData
);

	logic [`WISC_WORD_WIDTH-1:0] pc;

	// pc moves on every strobe, even when the queue later drops the word.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pc   <= `WISC_RESET_PC;
			push <= 1'b0;
		end
		else
		begin
			push <= instrValid;
			if (instrValid)
				pc <= pc + `WISC_PC_STEP;
		end
	end

	always_ff @(posedge clk)
	begin
		if (instrValid)
		begin
			pushData.pc    <= pc;
			pushData.instr <= instr;
		end
	end

endmodule

//--- verilog/control.sv
module control
(
	input  logic [4:0] opcode,
	output logic regDst,
	output logic aluSrc,
	output logic [4:0] aluOp,
	output logic branch,
	output logic memRead,
	output logic memWrite,
	output logic jump,
	output logic memToReg,
	output logic regWrite,
	output logic err,
	output logic halt,
	output logic zeroExt,
	output logic i1Fmt
);

	assign aluOp = opcode;

	always_comb
	begin
		regDst   = 1'b0;
		aluSrc   = 1'b0;
		branch   = 1'b0;
		memRead  = 1'b0;
		memWrite = 1'b0;
		jump     = 1'b0;
		memToReg = 1'b0;
		regWrite = 1'b0;
		err      = 1'b0;
		halt     = 1'b0;
		zeroExt  = 1'b0;
		i1Fmt    = 1'b0;
		case (opcode)
			5'b0_0000:
			begin
				halt = 1'b1;
			end
			5'b0_0001, 5'b0_0010, 5'b0_0011:
			begin
				// nop and friends set nothing.
			end
			5'b0_0100:
			begin
				jump = 1'b1;
			end
			5'b0_0101:
			begin
				jump = 1'b1; aluSrc = 1'b1;
			end
			5'b0_0110:
			begin
				jump = 1'b1; regWrite = 1'b1; // link.
			end
			5'b0_0111:
			begin
				jump = 1'b1; regWrite = 1'b1; aluSrc = 1'b1;
			end
			5'b0_1000, 5'b0_1001, 5'b1_0100, 5'b1_0101, 5'b1_0111:
			begin
				i1Fmt = 1'b1; aluSrc = 1'b1; regWrite = 1'b1;
			end
			5'b0_1010, 5'b0_1011:
			begin
				i1Fmt = 1'b1; aluSrc = 1'b1; regWrite = 1'b1; zeroExt = 1'b1;
			end
			5'b0_1100, 5'b0_1101, 5'b0_1110, 5'b0_1111:
			begin
				aluSrc = 1'b1; branch = 1'b1;
			end
			5'b1_0000:
			begin
				i1Fmt = 1'b1; aluSrc = 1'b1;
				memWrite = 1'b1; memRead = 1'b1; memToReg = 1'b1;
			end
			5'b1_0001:
			begin
				i1Fmt = 1'b1; aluSrc = 1'b1;
				memRead = 1'b1; memToReg = 1'b1; regWrite = 1'b1;
			end
			5'b1_0010:
			begin
				regWrite = 1'b1; aluSrc = 1'b1; zeroExt = 1'b1;
			end
			5'b1_0011:
			begin
				i1Fmt = 1'b1; aluSrc = 1'b1;
				memWrite = 1'b1; memRead = 1'b1; regWrite = 1'b1;
			end
			5'b1_0110:
			begin
				i1Fmt = 1'b1; regWrite = 1'b1;
			end
			5'b1_1000:
			begin
				regWrite = 1'b1; aluSrc = 1'b1;
			end
			5'b1_1001, 5'b1_1010, 5'b1_1011, 5'b1_1100,
			5'b1_1101, 5'b1_1110, 5'b1_1111:
			begin
				regDst = 1'b1; regWrite = 1'b1;
			end
			default:
			begin
				err = 1'b1; // only reached on x or z.
			end
		endcase
	end

endmodule

//--- verilog/wiscPkg.sv
`include "wiscDecode_macros.svh"

package wiscPkg;

	// tagged word from the fetch stage, 32 bits.
	typedef struct packed
	{
		logic [`WISC_WORD_WIDTH-1:0] pc;
		logic [`WISC_WORD_WIDTH-1:0] instr;
	} fetchPacket;

	// control bits from the control unit, 16 bits.
	typedef struct packed
	{
		logic [4:0] aluOp;
		logic regDst;
		logic aluSrc;
		logic branch;
		logic memRead;
		logic memWrite;
		logic jump;
		logic memToReg;
		logic regWrite;
		logic halt;
		logic zeroExt;
		logic i1Fmt;
	} ctrlSignals;

	// decode stage output, 57 bits.
	typedef struct packed
	{
		logic [`WISC_WORD_WIDTH-1:0] pc;
		ctrlSignals ctrl;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] writeReg;
		logic [`WISC_WORD_WIDTH-1:0] immediate; // already extended.
	} decodedPacket;

endpackage

//--- verilog/wiscDecode_macros.svh
`ifndef WISC_DECODE_MACROS_SVH
`define WISC_DECODE_MACROS_SVH

// instruction word and program counter share one width.
`define WISC_WORD_WIDTH 16

// default number of instruction queue entries.
`define WISC_QUEUE_DEPTH 8

// program counter value after reset.
`define WISC_RESET_PC 16'd0

// byte step per fetched instruction.
`define WISC_PC_STEP 16'd2

`endif
